// File: sm83_ctrl_config.svh
`ifndef SM83_CTRL_CONFIG_SVH
`define SM83_CTRL_CONFIG_SVH

// Opcode byte width
`define OPCODE_W 8

// Machine-cycle counter width
`define MCYCLE_W 3

// Highest machine cycle any legal instruction reaches
`define LAST_MCYCLE 5

`endif

// File: sm83_ctrl_pkg.sv
package sm83_ctrl_pkg;

    // Instruction groups seen by the sequencer
    typedef enum logic [3:0] {
        CLS_OTHER,
        CLS_JR,
        CLS_JP,
        CLS_CALL,
        CLS_RET,
        CLS_RET_CC,
        CLS_RST,
        CLS_PUSH,
        CLS_LOAD16,     // POP and LD rr,nn
        CLS_STOP,
        CLS_HALT,
        CLS_INVALID
    } instr_class_t;

    typedef enum logic [2:0] {
        COND_ALWAYS,
        COND_NZ,
        COND_Z,
        COND_NC,
        COND_C
    } cond_t;

    // One machine cycle of work
    typedef enum logic [3:0] {
        STEP_FETCH,
        STEP_OPERAND,
        STEP_REL_JUMP,
        STEP_ABS_JUMP,
        STEP_SP_DEC,
        STEP_PUSH,
        STEP_PUSH_LAST,
        STEP_CALL_JUMP,
        STEP_RST_JUMP,
        STEP_SP_READ,
        STEP_RET_LO,
        STEP_RET_HI
    } step_t;

    typedef enum logic [1:0] {BUS_IDLE = 2'd0, BUS_FETCH = 2'd1, BUS_WRITE = 2'd2, BUS_READ = 2'd3} bus_op_t;
    typedef enum logic [1:0] {AB_PC = 2'd0, AB_SP = 2'd3} ab_src_t;
    typedef enum logic [1:0] {CT_HOLD = 2'd0, CT_PC_INC = 2'd1, CT_SP_DEC = 2'd2, CT_SP_INC = 2'd3} ct_op_t;
    typedef enum logic [1:0] {PC_SRC_INC = 2'd0, PC_SRC_RST = 2'd1, PC_SRC_TMP = 2'd2} pc_src_t;

endpackage

// File: pc_ctrl_if.sv
`timescale 1ns/1ps

interface pc_ctrl_if import sm83_ctrl_pkg::*; ();

    pc_src_t pc_src;
    logic    pc_we;
    logic    pc_b_sel;     // Low or high byte of PC
    logic    pc_jr;

    modport drv (output pc_src, output pc_we, output pc_b_sel, output pc_jr);

    modport rcv (input pc_src, input pc_we, input pc_b_sel, input pc_jr);

endinterface

// File: opcode_classifier.sv
`timescale 1ns/1ps
`include "sm83_ctrl_config.svh"

module opcode_classifier import sm83_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [`OPCODE_W-1:0] opcode_early,
    output instr_class_t         cls,
    output cond_t                cond
);

    logic [`OPCODE_W-1:0] opcode;

    // Opcode arrives one clock ahead of its first machine cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opcode <= '0;
        end else begin
            opcode <= opcode_early;
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction group
    ////////////////////////////////////////////////////////////

    always_comb begin
        cls = CLS_OTHER;
        case (opcode)
            8'h18, 8'h20, 8'h28, 8'h30, 8'h38: begin
                cls = CLS_JR;
            end
            8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA: begin
                cls = CLS_JP;
            end
            8'hCD, 8'hC4, 8'hCC, 8'hD4, 8'hDC: begin
                cls = CLS_CALL;
            end
            8'hC9: cls = CLS_RET;
            8'hC0, 8'hC8, 8'hD0, 8'hD8: begin
                cls = CLS_RET_CC;
            end
            8'hC7, 8'hCF, 8'hD7, 8'hDF, 8'hE7, 8'hEF, 8'hF7, 8'hFF: begin
                cls = CLS_RST;
            end
            8'hC5, 8'hD5, 8'hE5, 8'hF5: begin
                cls = CLS_PUSH;
            end
            8'h01, 8'h11, 8'h21, 8'h31,            // LD rr,nn
            8'hC1, 8'hD1, 8'hE1, 8'hF1: begin     // POP rr
                cls = CLS_LOAD16;
            end
            8'h10: cls = CLS_STOP;
            8'h76: cls = CLS_HALT;
            // Holes in the SM83 opcode map
            8'hD3, 8'hDB, 8'hDD, 8'hE3, 8'hE4, 8'hEB,
            8'hEC, 8'hED, 8'hF4, 8'hFC, 8'hFD: begin
                cls = CLS_INVALID;
            end
            default: cls = CLS_OTHER;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Branch condition field
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            8'h20, 8'hC0, 8'hC2, 8'hC4: cond = COND_NZ;
            8'h28, 8'hC8, 8'hCA, 8'hCC: cond = COND_Z;
            8'h30, 8'hD0, 8'hD2, 8'hD4: cond = COND_NC;
            8'h38, 8'hD8, 8'hDA, 8'hDC: cond = COND_C;
            default:                    cond = COND_ALWAYS;
        endcase
    end

endmodule

// File: cycle_sequencer.sv
`timescale 1ns/1ps
`include "sm83_ctrl_config.svh"

module cycle_sequencer import sm83_ctrl_pkg::*; (
    input  instr_class_t         cls,
    input  cond_t                cond,
    input  logic [`MCYCLE_W-1:0] m_cycle,
    input  logic                 f_z,
    input  logic                 f_c,
    output step_t                step,
    output logic                 next,
    output logic                 stop,
    output logic                 halt
);

    localparam logic [`MCYCLE_W-1:0] MC1 = `MCYCLE_W'(1);
    localparam logic [`MCYCLE_W-1:0] MC2 = `MCYCLE_W'(2);
    localparam logic [`MCYCLE_W-1:0] MC3 = `MCYCLE_W'(3);
    localparam logic [`MCYCLE_W-1:0] MC4 = `MCYCLE_W'(4);

    logic taken;

    always_comb begin
        case (cond)
            COND_NZ: taken = !f_z;
            COND_Z:  taken = f_z;
            COND_NC: taken = !f_c;
            COND_C:  taken = f_c;
            default: taken = 1'b1;  // Unconditional forms
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Per-cycle step selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        step = STEP_FETCH;
        next = 1'b0;
        stop = 1'b0;
        halt = 1'b0;
        if (m_cycle > `MCYCLE_W'(`LAST_MCYCLE)) begin
            // Counter ran past any real instruction
            stop = 1'b1;
            halt = 1'b1;
            next = 1'b1;
        end else if (m_cycle == '0) begin
            stop = (cls == CLS_STOP) || (cls == CLS_INVALID);
            halt = (cls == CLS_HALT) || (cls == CLS_INVALID);
            next = cls inside {CLS_JR, CLS_JP, CLS_CALL, CLS_RET, CLS_RET_CC,
                               CLS_RST, CLS_PUSH, CLS_LOAD16};
        end else begin
            case (cls)
                CLS_JR: begin
                    if (m_cycle == MC1 && taken) step = STEP_REL_JUMP;
                end
                CLS_JP: begin
                    if (m_cycle == MC1) step = STEP_OPERAND;
                    if (m_cycle == MC2 && taken) step = STEP_ABS_JUMP;
                end
                CLS_CALL: begin
                    case (m_cycle)
                        MC1:     step = STEP_OPERAND;
                        MC2:     step = taken ? STEP_SP_DEC : STEP_FETCH;
                        MC3:     step = STEP_PUSH;
                        MC4:     step = STEP_CALL_JUMP;
                        default: step = STEP_FETCH;
                    endcase
                end
                CLS_RET: begin
                    if (m_cycle == MC1) step = STEP_RET_LO;
                    if (m_cycle == MC2) step = STEP_RET_HI;
                end
                CLS_RET_CC: begin
                    case (m_cycle)
                        MC1:     step = taken ? STEP_SP_READ : STEP_FETCH;
                        MC2:     step = STEP_RET_LO;
                        MC3:     step = STEP_RET_HI;
                        default: step = STEP_FETCH;
                    endcase
                end
                CLS_RST: begin
                    if (m_cycle == MC1) step = STEP_PUSH;
                    if (m_cycle == MC2) step = STEP_RST_JUMP;
                end
                CLS_PUSH: begin
                    if (m_cycle == MC1) step = STEP_PUSH;
                    if (m_cycle == MC2) step = STEP_PUSH_LAST;
                end
                CLS_LOAD16: begin
                    if (m_cycle == MC1) step = STEP_OPERAND;
                end
                default: step = STEP_FETCH;
            endcase
            // A fetch here is the overlapped fetch that closes the instruction
            next = (step != STEP_FETCH);
        end
    end

endmodule

// File: bus_step_decoder.sv
`timescale 1ns/1ps

module bus_step_decoder import sm83_ctrl_pkg::*; (
    input  step_t   step,
    output bus_op_t bus_op,
    output ab_src_t ab_src,
    output ct_op_t  ct_op
);

    always_comb begin
        bus_op = BUS_FETCH;
        ab_src = AB_PC;
        ct_op  = CT_PC_INC;
        case (step)
            STEP_ABS_JUMP, STEP_RET_HI: begin
                bus_op = BUS_IDLE;
                ct_op  = CT_HOLD;
            end
            STEP_SP_DEC: begin
                bus_op = BUS_IDLE;
                ct_op  = CT_SP_DEC;  // Make room before the first push
            end
            STEP_PUSH: begin
                bus_op = BUS_WRITE;
                ab_src = AB_SP;
                ct_op  = CT_SP_DEC;
            end
            STEP_PUSH_LAST, STEP_CALL_JUMP, STEP_RST_JUMP: begin
                bus_op = BUS_WRITE;
                ab_src = AB_SP;
                ct_op  = CT_HOLD;
            end
            STEP_SP_READ, STEP_RET_LO: begin
                bus_op = BUS_READ;
                ab_src = AB_SP;
                ct_op  = CT_SP_INC;
            end
            default: ;               // Fetch, operand, relative jump
        endcase
    end

endmodule

// File: pc_step_decoder.sv
`timescale 1ns/1ps
`include "sm83_ctrl_config.svh"

module pc_step_decoder import sm83_ctrl_pkg::*; (
    input  step_t                step,
    input  logic [`MCYCLE_W-1:0] m_cycle,
    pc_ctrl_if.drv               pc
);

    ////////////////////////////////////////////////////////////
    // PC source, write and byte select
    ////////////////////////////////////////////////////////////

    always_comb begin
        pc.pc_src   = PC_SRC_INC;
        pc.pc_we    = 1'b0;
        pc.pc_jr    = (step == STEP_REL_JUMP);
        pc.pc_b_sel = m_cycle[0];  // Byte follows cycle parity
        case (step)
            STEP_ABS_JUMP, STEP_CALL_JUMP: begin
                pc.pc_src = PC_SRC_TMP;
                pc.pc_we  = 1'b1;
            end
            STEP_RST_JUMP: begin
                pc.pc_src = PC_SRC_RST;
                pc.pc_we  = 1'b1;
            end
            // Return address comes off the stack low byte first
            STEP_RET_LO: begin
                pc.pc_b_sel = 1'b0;
            end
            STEP_RET_HI: begin
                pc.pc_b_sel = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: sm83_control.sv
`timescale 1ns/1ps
`include "sm83_ctrl_config.svh"

module sm83_control import sm83_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [`OPCODE_W-1:0] opcode_early,
    input  logic [`MCYCLE_W-1:0] m_cycle,
    input  logic                 f_z,
    input  logic                 f_c,
    output bus_op_t              bus_op,
    output ab_src_t              ab_src,
    output ct_op_t               ct_op,
    output pc_src_t              pc_src,
    output logic                 pc_we,
    output logic                 pc_b_sel,
    output logic                 pc_jr,
    output logic                 next,
    output logic                 stop,
    output logic                 halt
);

    instr_class_t cls;
    cond_t        cond;
    step_t        step;

    pc_ctrl_if pc_bus ();

    opcode_classifier u_classifier (
        .clk, .arst_n, .opcode_early, .cls, .cond
    );

    cycle_sequencer u_sequencer (
        .cls, .cond, .m_cycle, .f_z, .f_c, .step, .next, .stop, .halt
    );

    bus_step_decoder u_bus_dec (.step, .bus_op, .ab_src, .ct_op);

    pc_step_decoder u_pc_dec (.step, .m_cycle, .pc(pc_bus.drv));

    // PC controls out to the datapath
    assign pc_src   = pc_bus.pc_src;
    assign pc_we    = pc_bus.pc_we;
    assign pc_b_sel = pc_bus.pc_b_sel;
    assign pc_jr    = pc_bus.pc_jr;

endmodule

// File: tb_sm83_control.sv
`timescale 1ns/1ps
`include "sm83_ctrl_config.svh"

module tb_sm83_control;

    localparam int N_INSTR    = 400;
    localparam int MAX_CYCLES = N_INSTR * 8 + 100;

    typedef enum int {
        K_OTHER, K_JR, K_JP, K_CALL, K_RET, K_RET_CC,
        K_RST, K_PUSH, K_LOAD16, K_STOP, K_HALT, K_INVALID
    } model_class_e;

    typedef enum int {
        S_FETCH, S_OPERAND, S_REL_JUMP, S_ABS_JUMP, S_SP_DEC, S_PUSH,
        S_PUSH_LAST, S_CALL_JUMP, S_RST_JUMP, S_SP_READ, S_RET_LO, S_RET_HI
    } model_step_e;

    logic                 clk;
    logic                 arst_n;
    logic [`OPCODE_W-1:0] opcode_early;
    logic [`MCYCLE_W-1:0] m_cycle;
    logic                 f_z;
    logic                 f_c;
    logic [1:0]           bus_op;
    logic [1:0]           ab_src;
    logic [1:0]           ct_op;
    logic [1:0]           pc_src;
    logic                 pc_we;
    logic                 pc_b_sel;
    logic                 pc_jr;
    logic                 next;
    logic                 stop;
    logic                 halt;

    int         e_bus, e_ab, e_ct, e_src, e_we;
    int         e_bsel, e_jr, e_next, e_stop, e_halt;
    int         step_table [0:11][0:5];  // Step per class and machine cycle
    int         cond_cycle [0:11];       // Cycle that tests the condition, 0 if none
    logic [7:0] op_table [0:52];
    logic [31:0] lfsr;
    int         cycle_count = 0;

    sm83_control UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d clock cycles", MAX_CYCLES);
            $display("test failed");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Random bits and checking
    ////////////////////////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) lfsr = lfsr ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display("test failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic check_outputs(input string tag);
        check({tag, " bus_op"}, e_bus, 32'(bus_op));
        check({tag, " ab_src"}, e_ab, 32'(ab_src));
        check({tag, " ct_op"}, e_ct, 32'(ct_op));
        check({tag, " pc_src"}, e_src, 32'(pc_src));
        check({tag, " pc_we"}, e_we, 32'(pc_we));
        check({tag, " pc_b_sel"}, e_bsel, 32'(pc_b_sel));
        check({tag, " pc_jr"}, e_jr, 32'(pc_jr));
        check({tag, " next"}, e_next, 32'(next));
        check({tag, " stop"}, e_stop, 32'(stop));
        check({tag, " halt"}, e_halt, 32'(halt));
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic int op_class(input logic [7:0] op);
        case (op)
            8'h18, 8'h20, 8'h28, 8'h30, 8'h38: op_class = K_JR;
            8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA: op_class = K_JP;
            8'hCD, 8'hC4, 8'hCC, 8'hD4, 8'hDC: op_class = K_CALL;
            8'hC9:                             op_class = K_RET;
            8'hC0, 8'hC8, 8'hD0, 8'hD8:        op_class = K_RET_CC;
            8'hC7, 8'hCF, 8'hD7, 8'hDF,
            8'hE7, 8'hEF, 8'hF7, 8'hFF:        op_class = K_RST;
            8'hC5, 8'hD5, 8'hE5, 8'hF5:        op_class = K_PUSH;
            8'h01, 8'h11, 8'h21, 8'h31,
            8'hC1, 8'hD1, 8'hE1, 8'hF1:        op_class = K_LOAD16;
            8'h10:                             op_class = K_STOP;
            8'h76:                             op_class = K_HALT;
            8'hD3, 8'hDB, 8'hDD, 8'hE3, 8'hE4, 8'hEB,
            8'hEC, 8'hED, 8'hF4, 8'hFC, 8'hFD: op_class = K_INVALID;
            default:                           op_class = K_OTHER;
        endcase
    endfunction

    // 1 NZ, 2 Z, 3 NC, 4 C, 0 always
    function automatic int op_cond(input logic [7:0] op);
        case (op)
            8'h20, 8'hC0, 8'hC2, 8'hC4: op_cond = 1;
            8'h28, 8'hC8, 8'hCA, 8'hCC: op_cond = 2;
            8'h30, 8'hD0, 8'hD2, 8'hD4: op_cond = 3;
            8'h38, 8'hD8, 8'hDA, 8'hDC: op_cond = 4;
            default:                    op_cond = 0;
        endcase
    endfunction

    task automatic init_model();
        int c;
        int m;
        for (c = 0; c < 12; c++) begin
            cond_cycle[c] = 0;
            for (m = 0; m < 6; m++) step_table[c][m] = S_FETCH;
        end
        step_table[K_JR][1]     = S_REL_JUMP;
        step_table[K_JP][1]     = S_OPERAND;
        step_table[K_JP][2]     = S_ABS_JUMP;
        step_table[K_CALL][1]   = S_OPERAND;
        step_table[K_CALL][2]   = S_SP_DEC;
        step_table[K_CALL][3]   = S_PUSH;
        step_table[K_CALL][4]   = S_CALL_JUMP;
        step_table[K_RET][1]    = S_RET_LO;
        step_table[K_RET][2]    = S_RET_HI;
        step_table[K_RET_CC][1] = S_SP_READ;
        step_table[K_RET_CC][2] = S_RET_LO;
        step_table[K_RET_CC][3] = S_RET_HI;
        step_table[K_RST][1]    = S_PUSH;
        step_table[K_RST][2]    = S_RST_JUMP;
        step_table[K_PUSH][1]   = S_PUSH;
        step_table[K_PUSH][2]   = S_PUSH_LAST;
        step_table[K_LOAD16][1] = S_OPERAND;
        cond_cycle[K_JR]     = 1;
        cond_cycle[K_JP]     = 2;
        cond_cycle[K_CALL]   = 2;
        cond_cycle[K_RET_CC] = 1;
        op_table = '{8'h18, 8'h20, 8'h28, 8'h30, 8'h38, 8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA,
                     8'hCD, 8'hC4, 8'hCC, 8'hD4, 8'hDC, 8'hC9, 8'hC0, 8'hC8, 8'hD0, 8'hD8,
                     8'hC7, 8'hCF, 8'hD7, 8'hDF, 8'hE7, 8'hEF, 8'hF7, 8'hFF, 8'hC5, 8'hD5,
                     8'hE5, 8'hF5, 8'h01, 8'h11, 8'h21, 8'h31, 8'hC1, 8'hD1, 8'hE1, 8'hF1,
                     8'h10, 8'h76, 8'hD3, 8'hDB, 8'hDD, 8'hE3, 8'hE4, 8'hEB, 8'hEC, 8'hED,
                     8'hF4, 8'hFC, 8'hFD};
    endtask

    task automatic model_outputs(input logic [7:0] op, input int mc, input logic fz, input logic fc);
        int         cls;
        int         stp;
        logic       taken;
        logic [5:0] codes;
        cls = op_class(op);
        case (op_cond(op))
            1:       taken = !fz;
            2:       taken = fz;
            3:       taken = !fc;
            4:       taken = fc;
            default: taken = 1'b1;
        endcase
        stp = S_FETCH;
        if (mc > `LAST_MCYCLE) begin
            e_stop = 1;
            e_halt = 1;
            e_next = 1;
        end else if (mc == 0) begin
            e_stop = int'(cls == K_STOP || cls == K_INVALID);
            e_halt = int'(cls == K_HALT || cls == K_INVALID);
            e_next = int'(cls >= K_JR && cls <= K_LOAD16);
        end else begin
            stp = step_table[cls][mc];
            if (cond_cycle[cls] == mc && !taken) stp = S_FETCH;  // Not taken ends here
            e_stop = 0;
            e_halt = 0;
            e_next = int'(stp != S_FETCH);
        end
        // {bus_op, ab_src, ct_op}
        case (stp)
            S_ABS_JUMP, S_RET_HI:                 codes = {2'd0, 2'd0, 2'd0};
            S_SP_DEC:                             codes = {2'd0, 2'd0, 2'd2};
            S_PUSH:                               codes = {2'd2, 2'd3, 2'd2};
            S_PUSH_LAST, S_CALL_JUMP, S_RST_JUMP: codes = {2'd2, 2'd3, 2'd0};
            S_SP_READ, S_RET_LO:                  codes = {2'd3, 2'd3, 2'd3};
            default:                              codes = {2'd1, 2'd0, 2'd1};
        endcase
        e_bus  = int'(codes[5:4]);
        e_ab   = int'(codes[3:2]);
        e_ct   = int'(codes[1:0]);
        e_jr   = int'(stp == S_REL_JUMP);
        e_we   = int'(stp == S_ABS_JUMP || stp == S_CALL_JUMP || stp == S_RST_JUMP);
        e_src  = (stp == S_ABS_JUMP || stp == S_CALL_JUMP) ? 2 : (stp == S_RST_JUMP) ? 1 : 0;
        e_bsel = (stp == S_RET_LO) ? 0 : (stp == S_RET_HI) ? 1 : (mc & 1);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic apply_cycle(input logic [7:0] op, input int mc);
        logic fz;
        logic fc;
        @(negedge clk);
        fz = lfsr_bit();
        fc = lfsr_bit();
        m_cycle = 3'(mc);
        f_z = fz;
        f_c = fc;
        #5;  // Mid low phase
        model_outputs(op, mc, fz, fc);
        check_outputs($sformatf("op %02h m%0d", op, mc));
    endtask

    task automatic run_instruction(input logic [7:0] op);
        int mc;
        @(negedge clk);
        opcode_early = op;
        m_cycle = '0;
        mc = 0;
        do begin
            apply_cycle(op, mc);
            mc++;
        end while (e_next != 0 && mc <= `LAST_MCYCLE);
    endtask

    task automatic run_fault_cycles(input logic [7:0] op);
        @(negedge clk);
        opcode_early = op;
        m_cycle = '0;
        apply_cycle(op, 6);
        apply_cycle(op, 7);
    endtask

    initial begin
        int i;
        logic [7:0] op;
        clk = 1'b0;
        arst_n = 1'b0;
        opcode_early = 8'hC3;  // Reset must win over this
        m_cycle = '0;
        f_z = 1'b0;
        f_c = 1'b0;
        lfsr = 32'hcfa8_b771;
        init_model();
        repeat (3) @(negedge clk);
        #5;
        model_outputs(8'h00, 0, 1'b0, 1'b0);
        check_outputs("reset");
        @(negedge clk);
        arst_n = 1'b1;
        for (i = 0; i < N_INSTR; i++) begin
            if (rand_bits(2) != 0) op = op_table[rand_bits(6) % 53];
            else op = 8'(rand_bits(8));
            run_instruction(op);
        end
        run_fault_cycles(8'h00);
        run_fault_cycles(8'hCD);
        run_fault_cycles(8'h76);
        run_fault_cycles(8'hD3);
        $display("test passed");
        $finish;
    end

endmodule

// File: sm83_control.f
+incdir+.
sm83_ctrl_pkg.sv
pc_ctrl_if.sv
opcode_classifier.sv
cycle_sequencer.sv
bus_step_decoder.sv
pc_step_decoder.sv
sm83_control.sv
tb_sm83_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_sm83_control -f sm83_control.f

out=$(./obj_dir/Vtb_sm83_control 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi
